// ==== Makefile ====
.PHONY: run build lint clean

run: build
	./obj_dir/Vfetch_tb 2>&1 | tee sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" sim.log; then echo "simulation incomplete"; exit 1; fi

build:
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f all.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module fetch_tb -f all.f

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
common/fetch_pkg.sv
design/sync_fifo.sv
design/fetch_ctrl.sv
design/inst_align.sv
predecode/ret_stack.sv
predecode/predecode.sv
design/fetch_top.sv
tb/fetch_properties.sv
tb/fetch_tb.sv

// ==== common/fetch_pkg.sv ====
// fetch front end sizes, bus and line structs, instruction kinds and output beat
package fetch_pkg;

    localparam int XLEN             = 64;
    localparam int LINE_HALVES      = 8;
    localparam int LINE_BITS        = 128;
    localparam int LINE_QUEUE_DEPTH = 4;
    localparam int INST_QUEUE_DEPTH = 4;
    localparam int RAS_DEPTH        = 8;
    localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;
    localparam int OUTSTANDING_MAX  = 4;  // in-flight requests plus queued lines

    typedef struct packed {
        logic [XLEN-1:0] addr;            // line aligned
    } mem_req_t;

    typedef struct packed {
        logic [LINE_BITS-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic [XLEN-1:0]      addr;
        logic [LINE_BITS-1:0] data;
    } line_t;

    typedef enum logic [2:0] {
        KIND_SEQ,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR
    } inst_kind_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     ir;              // upper half zero when compressed
        logic            compressed;
    } raw_inst_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     ir;
        logic            compressed;
        inst_kind_e      kind;
        logic            call;
        logic            ret;
        logic [XLEN-1:0] target;
        logic [XLEN-1:0] pred_npc;
    } fetch_out_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
    } redirect_t;

endpackage

// ==== design/fetch_ctrl.sv ====
// fetch PC sequencing, line requests, stale response dropping and redirect merge
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                                                clk,
    input  logic                                                rst,
    output logic                                                mem_req_valid,
    input  logic                                                mem_req_ready,
    output fetch_pkg::mem_req_t                                 mem_req,
    input  logic                                                mem_rsp_valid,
    input  fetch_pkg::mem_rsp_t                                 mem_rsp,
    input  logic                                                redirect_valid,
    input  fetch_pkg::redirect_t                                redirect,
    input  logic                                                jump_valid,
    input  logic [fetch_pkg::XLEN-1:0]                          jump_pc,
    output logic                                                line_push_valid,
    output fetch_pkg::line_t                                    line_push,
    input  logic [$clog2(fetch_pkg::LINE_QUEUE_DEPTH+1)-1:0]    line_count,
    output logic                                                flush,
    output logic [fetch_pkg::XLEN-1:0]                          restart_pc
);
    logic [fetch_pkg::XLEN-1:0] fetch_pc;     // address of the next request
    logic [fetch_pkg::XLEN-1:0] restart_line;
    logic [fetch_pkg::XLEN-1:0] pend_pc;
    logic                       pend;         // restart held behind a stalled request
    logic                       active;
    logic [$clog2(fetch_pkg::OUTSTANDING_MAX+1)-1:0] outstanding;
    logic [$clog2(fetch_pkg::OUTSTANDING_MAX+1)-1:0] outstanding_next;
    logic [$clog2(fetch_pkg::OUTSTANDING_MAX+1)-1:0] drop_cnt;
    logic [fetch_pkg::XLEN-1:0] addr_q [fetch_pkg::OUTSTANDING_MAX];
    logic [$clog2(fetch_pkg::OUTSTANDING_MAX)-1:0]   aq_wr;
    logic [$clog2(fetch_pkg::OUTSTANDING_MAX)-1:0]   aq_rd;
    logic                       req_fire;
    logic                       req_stall;
    logic                       stale_fire;
    logic                       rsp_drop;

    // backend redirect has priority over a predecode jump
    assign flush        = redirect_valid | jump_valid;
    assign restart_pc   = redirect_valid ? redirect.pc : jump_pc;
    assign restart_line = restart_pc & ~64'(fetch_pkg::LINE_BITS / 8 - 1);

    assign mem_req_valid = active &
        (int'(outstanding) + int'(line_count) < fetch_pkg::OUTSTANDING_MAX);
    assign mem_req.addr  = fetch_pc;
    assign req_fire      = mem_req_valid & mem_req_ready;
    assign req_stall     = mem_req_valid & ~mem_req_ready;
    assign stale_fire    = pend & req_fire;  // request carries a pre-flush address

    assign rsp_drop          = mem_rsp_valid & (drop_cnt != 0);
    assign line_push_valid   = mem_rsp_valid & (drop_cnt == 0);
    assign line_push.addr    = addr_q[aq_rd];
    assign line_push.data    = mem_rsp.data;

    always_comb begin
        outstanding_next = outstanding;
        if (req_fire) outstanding_next = outstanding_next + 1'b1;
        if (mem_rsp_valid) outstanding_next = outstanding_next - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active      <= 1'b0;
            fetch_pc    <= fetch_pkg::RESET_PC;
            pend        <= 1'b0;
            outstanding <= '0;
            drop_cnt    <= '0;
            aq_wr       <= '0;
            aq_rd       <= '0;
        end else begin
            active      <= 1'b1;
            outstanding <= outstanding_next;
            if (req_fire) aq_wr <= aq_wr + 1'b1;
            if (mem_rsp_valid) aq_rd <= aq_rd + 1'b1;  // dropped ones leave too
            if (flush) begin
                drop_cnt <= outstanding_next;         // everything in flight is stale
                pend     <= req_stall;
                if (!req_stall) fetch_pc <= restart_line;  // stalled address must hold
            end else begin
                if (stale_fire && !rsp_drop) drop_cnt <= drop_cnt + 1'b1;
                else if (rsp_drop && !stale_fire) drop_cnt <= drop_cnt - 1'b1;
                if (req_fire) begin
                    fetch_pc <= pend ? pend_pc : fetch_pc + 64'(fetch_pkg::LINE_BITS / 8);
                    pend     <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush) pend_pc <= restart_line;
        if (req_fire) addr_q[aq_wr] <= fetch_pc;
    end

endmodule

// ==== design/fetch_top.sv ====
// fetch front end top level with control, line queue, aligner, predecode and output queue
`timescale 1ns/1ps

module fetch_top (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output fetch_pkg::mem_req_t   mem_req,
    input  logic                  mem_rsp_valid,
    input  fetch_pkg::mem_rsp_t   mem_rsp,
    input  logic                  redirect_valid,
    input  fetch_pkg::redirect_t  redirect,
    output logic                  out_valid,
    input  logic                  out_ready,
    output fetch_pkg::fetch_out_t out
);
    logic                       line_push_valid;
    fetch_pkg::line_t           line_push;
    logic [$clog2(fetch_pkg::LINE_QUEUE_DEPTH+1)-1:0] line_count;
    logic                       flush;
    logic [fetch_pkg::XLEN-1:0] restart_pc;
    logic                       jump_valid;
    logic [fetch_pkg::XLEN-1:0] jump_pc;
    logic                       head_valid;
    logic                       second_valid;
    logic                       head_pop;
    fetch_pkg::line_t           head;
    fetch_pkg::line_t           second;
    logic                       inst_valid;
    logic                       inst_ready;
    fetch_pkg::raw_inst_t       inst;
    logic                       dec_valid;
    logic                       dec_ready;
    fetch_pkg::fetch_out_t      dec_data;
    logic                       queue_valid;

    assign out_valid = queue_valid & ~redirect_valid;  // no beat while the backend redirects

    fetch_ctrl ctrl_inst (
        .clk(clk), .rst(rst),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
        .redirect_valid(redirect_valid), .redirect(redirect),
        .jump_valid(jump_valid), .jump_pc(jump_pc),
        .line_push_valid(line_push_valid), .line_push(line_push), .line_count(line_count),
        .flush(flush), .restart_pc(restart_pc)
    );

    sync_fifo #(.DEPTH(fetch_pkg::LINE_QUEUE_DEPTH), .payload_t(fetch_pkg::line_t)) line_fifo (
        .clk(clk), .rst(rst), .flush(flush),
        .push_valid(line_push_valid), .push_ready(), .push_data(line_push),
        .pop_valid(head_valid), .pop_ready(head_pop), .pop_data(head),
        .second_valid(second_valid), .second_data(second), .count(line_count)
    );

    inst_align align_inst (
        .clk(clk), .rst(rst), .flush(flush), .restart_pc(restart_pc),
        .head_valid(head_valid), .head(head),
        .second_valid(second_valid), .second(second), .head_pop(head_pop),
        .inst_valid(inst_valid), .inst_ready(inst_ready), .inst(inst)
    );

    predecode predecode_inst (
        .clk(clk), .rst(rst), .flush(flush),
        .inst_valid(inst_valid), .inst_ready(inst_ready), .inst(inst),
        .push_valid(dec_valid), .push_ready(dec_ready), .push_data(dec_data),
        .jump_valid(jump_valid), .jump_pc(jump_pc), .backend_flush(redirect_valid)
    );

    // a jump keeps the queued beats and only the backend clears them
    sync_fifo #(
        .DEPTH(fetch_pkg::INST_QUEUE_DEPTH),
        .payload_t(fetch_pkg::fetch_out_t)
    ) inst_fifo (
        .clk(clk), .rst(rst), .flush(redirect_valid),
        .push_valid(dec_valid), .push_ready(dec_ready), .push_data(dec_data),
        .pop_valid(queue_valid), .pop_ready(out_ready), .pop_data(out),
        .second_valid(), .second_data(), .count()
    );

endmodule

// ==== design/inst_align.sv ====
// half-word cursor that cuts 16 and 32 bit instructions from the two oldest lines
`timescale 1ns/1ps

module inst_align (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic [fetch_pkg::XLEN-1:0] restart_pc,
    input  logic                       head_valid,
    input  fetch_pkg::line_t           head,
    input  logic                       second_valid,
    input  fetch_pkg::line_t           second,
    output logic                       head_pop,
    output logic                       inst_valid,
    input  logic                       inst_ready,
    output fetch_pkg::raw_inst_t       inst
);
    logic [$clog2(fetch_pkg::LINE_HALVES)-1:0] cursor;       // half-word in head line
    logic [$clog2(fetch_pkg::LINE_HALVES):0]   cursor_next;  // top bit marks wrap
    logic [15:0] lo_half;
    logic [15:0] hi_half;
    logic        compressed;
    logic        spans;
    logic        fire;

    assign lo_half    = head.data[{cursor, 4'b0000} +: 16];
    assign spans      = cursor == fetch_pkg::LINE_HALVES - 1;
    assign hi_half    = spans ? second.data[15:0] : head.data[{cursor + 1'b1, 4'b0000} +: 16];
    assign compressed = lo_half[1:0] != 2'b11;

    // a 32-bit instruction in the last slot needs the next line
    assign inst_valid = head_valid & (compressed | ~spans | second_valid);
    assign fire       = inst_valid & inst_ready;

    assign inst.pc         = head.addr + {cursor, 1'b0};
    assign inst.ir         = compressed ? {16'h0000, lo_half} : {hi_half, lo_half};
    assign inst.compressed = compressed;

    assign cursor_next = {1'b0, cursor} + (compressed ? 1'b1 : 2'd2);
    assign head_pop    = fire & cursor_next[$clog2(fetch_pkg::LINE_HALVES)];

    always_ff @(posedge clk) begin
        if (rst) begin
            cursor <= fetch_pkg::RESET_PC[$clog2(fetch_pkg::LINE_HALVES):1];
        end else if (flush) begin
            cursor <= restart_pc[$clog2(fetch_pkg::LINE_HALVES):1];  // skip leading halves
        end else if (fire) begin
            cursor <= cursor_next[$clog2(fetch_pkg::LINE_HALVES)-1:0];
        end
    end

endmodule

// ==== design/sync_fifo.sv ====
// synchronous circular FIFO with typed payload, flush and second-entry peek
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  DEPTH     = 4,      // power of two
    parameter type payload_t = logic
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       push_valid,
    output logic                       push_ready,
    input  payload_t                   push_data,
    output logic                       pop_valid,
    input  logic                       pop_ready,
    output payload_t                   pop_data,
    output logic                       second_valid,
    output payload_t                   second_data,
    output logic [$clog2(DEPTH+1)-1:0] count
);
    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic                       do_push;
    logic                       do_pop;

    assign push_ready   = count < DEPTH;
    assign pop_valid    = count != 0;
    assign second_valid = count > 1;
    assign pop_data     = mem[rd_ptr];
    assign second_data  = mem[rd_ptr + 1'b1];  // wraps with the pointer
    assign do_push      = push_valid & push_ready;
    assign do_pop       = pop_valid & pop_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin            // flush drops every entry at once
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

// ==== predecode/predecode.sv ====
// instruction classification, branch and jump targets, return prediction and jump redirect
`timescale 1ns/1ps

module predecode (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       inst_valid,
    output logic                       inst_ready,
    input  fetch_pkg::raw_inst_t       inst,
    output logic                       push_valid,
    input  logic                       push_ready,
    output fetch_pkg::fetch_out_t      push_data,
    output logic                       jump_valid,
    output logic [fetch_pkg::XLEN-1:0] jump_pc,
    input  logic                       backend_flush
);
    logic [31:0]                ir;
    logic [4:0]                 rd;
    logic [4:0]                 rs1;
    logic [fetch_pkg::XLEN-1:0] seq_npc;
    logic [fetch_pkg::XLEN-1:0] target;
    logic [fetch_pkg::XLEN-1:0] ras_top;
    logic                       ras_empty;
    logic                       is_branch;
    logic                       is_jal;
    logic                       is_jalr;
    logic                       call;
    logic                       ret;
    logic                       taken;
    logic                       fire;
    fetch_pkg::inst_kind_e      kind;

    assign ir      = inst.ir;
    assign rd      = ir[11:7];
    assign rs1     = ir[19:15];
    assign seq_npc = inst.pc + (inst.compressed ? 64'd2 : 64'd4);

    always_comb begin
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        call      = 1'b0;
        ret       = 1'b0;
        target    = seq_npc;
        if (!inst.compressed) begin
            case (ir[6:0])
                7'b1100011: begin  // branch
                    is_branch = 1'b1;
                    target    = inst.pc + {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
                end
                7'b1101111: begin  // jal
                    is_jal = 1'b1;
                    call   = rd == 5'd1 || rd == 5'd5;
                    target = inst.pc + {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
                end
                7'b1100111: begin  // jalr with rs1 equal to rd counts as call only
                    is_jalr = 1'b1;
                    call    = rd == 5'd1 || rd == 5'd5;
                    ret     = (rs1 == 5'd1 || rs1 == 5'd5) && rs1 != rd;
                end
                default: ;
            endcase
        end else if (ir[1:0] == 2'b01 && ir[15:13] == 3'b101) begin  // c.j
            is_jal = 1'b1;
            target = inst.pc + {{53{ir[12]}}, ir[8], ir[10:9], ir[6], ir[7], ir[2], ir[11],
                                ir[5:3], 1'b0};
        end else if (ir[1:0] == 2'b01 && ir[15:14] == 2'b11) begin  // c.beqz, c.bnez
            is_branch = 1'b1;
            target    = inst.pc + {{56{ir[12]}}, ir[6:5], ir[2], ir[11:10], ir[4:3], 1'b0};
        end else if (ir[1:0] == 2'b10 && ir[15:13] == 3'b100 && ir[6:2] == 5'd0
                     && rd != 5'd0) begin
            is_jalr = 1'b1;        // c.jr or c.jalr
            call    = ir[12];
            ret     = !ir[12] && (rd == 5'd1 || rd == 5'd5);
        end
        if (ret && !ras_empty) target = ras_top;
    end

    always_comb begin
        kind = fetch_pkg::KIND_SEQ;
        if (is_branch) kind = fetch_pkg::KIND_BRANCH;
        if (is_jal) kind = fetch_pkg::KIND_JAL;
        if (is_jalr) kind = fetch_pkg::KIND_JALR;
    end

    assign taken      = is_jal | (ret & ~ras_empty);  // branches predicted not taken
    assign inst_ready = push_ready;
    assign push_valid = inst_valid & ~backend_flush;
    assign fire       = push_valid & push_ready;
    assign jump_valid = fire & taken;
    assign jump_pc    = target;

    assign push_data.pc         = inst.pc;
    assign push_data.ir         = ir;
    assign push_data.compressed = inst.compressed;
    assign push_data.kind       = kind;
    assign push_data.call       = call;
    assign push_data.ret        = ret;
    assign push_data.target     = target;
    assign push_data.pred_npc   = taken ? target : seq_npc;

    ret_stack ras_inst (
        .clk       (clk),
        .rst       (rst),
        .clear     (backend_flush),
        .push      (fire & call),
        .pop       (fire & ret),
        .push_addr (seq_npc),
        .top       (ras_top),
        .empty     (ras_empty)
    );

endmodule

// ==== predecode/ret_stack.sv ====
// circular return address stack with saturating occupancy
`timescale 1ns/1ps

module ret_stack (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  logic                       push,
    input  logic                       pop,
    input  logic [fetch_pkg::XLEN-1:0] push_addr,
    output logic [fetch_pkg::XLEN-1:0] top,
    output logic                       empty
);
    logic [fetch_pkg::XLEN-1:0]                 mem [fetch_pkg::RAS_DEPTH];
    logic [$clog2(fetch_pkg::RAS_DEPTH)-1:0]    tos;   // index of the top entry
    logic [$clog2(fetch_pkg::RAS_DEPTH):0]      cnt;
    logic                                       do_pop;

    assign top    = mem[tos];
    assign empty  = cnt == 0;
    assign do_pop = pop & ~empty;   // pop on empty is ignored

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            tos <= '0;
            cnt <= '0;
        end else if (push && !do_pop) begin
            tos <= tos + 1'b1;      // wraps over the oldest entry
            if (cnt != fetch_pkg::RAS_DEPTH) cnt <= cnt + 1'b1;
        end else if (do_pop && !push) begin
            tos <= tos - 1'b1;
            cnt <= cnt - 1'b1;
        end
    end

    // push with pop rewrites the current top in place
    always_ff @(posedge clk) begin
        if (push) mem[do_pop ? tos : tos + 1'b1] <= push_addr;
    end

endmodule

// ==== tb/fetch_properties.sv ====
// handshake stability and redirect blanking assertions for the fetch front end
`timescale 1ns/1ps

module fetch_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  mem_req_valid,
    input logic                  mem_req_ready,
    input fetch_pkg::mem_req_t   mem_req,
    input logic                  redirect_valid,
    input logic                  out_valid,
    input logic                  out_ready,
    input fetch_pkg::fetch_out_t out
);
    int violations = 0;  // failed assertions so far

    out_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out))
        else begin
            violations++;
            $error("out changed while the output channel was stalled");
        end

    req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else begin
            violations++;
            $error("memory request dropped or changed while stalled");
        end

    // queued beats are gone once the redirect has been taken
    no_beat_on_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> !out_valid ##1 !out_valid)
        else begin
            violations++;
            $error("out_valid high during a backend redirect or in the cycle after it");
        end

endmodule

// ==== tb/fetch_tb.sv ====
// fetch front end testbench with clock, reset, memory model, random stimulus and reference model
`timescale 1ns/1ps

module fetch_tb;
    localparam int BEATS       = 3000;
    localparam int WATCHDOG_NS = BEATS * 20 * 20;  // 20 cycles of 20 ns per beat

    logic                       clk;
    logic                       rst;
    logic                       mem_req_valid;
    logic                       mem_req_ready;
    fetch_pkg::mem_req_t        mem_req;
    logic                       mem_rsp_valid;
    fetch_pkg::mem_rsp_t        mem_rsp;
    logic                       redirect_valid;
    fetch_pkg::redirect_t       redirect;
    logic                       out_valid;
    logic                       out_ready;
    fetch_pkg::fetch_out_t      out;

    logic [15:0]                halves [2048];  // 256 lines of 8 half-words
    logic [fetch_pkg::XLEN-1:0] rsp_addr [$];   // accepted requests in order
    longint                     rsp_due [$];
    logic [fetch_pkg::XLEN-1:0] ras [$];        // model stack with the newest at the back
    logic [fetch_pkg::XLEN-1:0] model_pc;
    longint                     cycle;
    longint                     last_due;
    int                         beats;
    int                         gap;            // cycles to the next backend redirect
    int                         errors;

    fetch_top fetch_top_inst (
        .clk(clk), .rst(rst),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
        .redirect_valid(redirect_valid), .redirect(redirect),
        .out_valid(out_valid), .out_ready(out_ready), .out(out)
    );

    bind fetch_top fetch_properties fetch_props_inst (
        .clk(clk), .rst(rst),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .redirect_valid(redirect_valid),
        .out_valid(out_valid), .out_ready(out_ready), .out(out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [15:0] half_at(input logic [fetch_pkg::XLEN-1:0] a);
        return halves[a[11:1]];
    endfunction

    function automatic logic [fetch_pkg::LINE_BITS-1:0] line_data(input logic [63:0] addr);
        logic [fetch_pkg::LINE_BITS-1:0] d;
        for (int i = 0; i < fetch_pkg::LINE_HALVES; i++) begin
            d[i*16 +: 16] = half_at(addr + 64'(2 * i));
        end
        return d;
    endfunction

    // a third of the mix is jal, call or ret and compressed forms leave the upper half zero
    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [11:0] off;
        int          sel;
        r   = $urandom;
        off = {r[31:21], 1'b0};
        sel = $urandom_range(0, 23);
        case (sel)
            0, 1:    return {off[11], off[10:1], off[11], {8{off[11]}}, 5'd0, 7'h6f};  // j
            2:       return {off[11], off[10:1], off[11], {8{off[11]}}, 5'd1, 7'h6f};  // call
            3:       return {16'h0000, 4'b1001, r[11:8], 1'b1, 5'd0, 2'b10};           // c.jalr
            4:       return {r[31:15], 3'b000, r[0] ? 5'd1 : 5'd5, 7'h67};             // jalr call
            5:       return 32'h0000_8067;                                          // ret x1
            6:       return r[0] ? 32'h0000_8082 : 32'h0000_8282;                   // c.jr x1/x5
            7:       return 32'h0002_8067;                                          // ret x5
            8, 9:    return {off[11], off[10:5], r[14:5], r[2:0], off[4:1], off[11], 7'h63};
            10, 11:  return {16'h0000, r[0] ? 3'b101 : {2'b11, r[1]}, r[12:2], 2'b01};
            12, 13, 14, 15, 16, 17: return {r[31:2], 2'b11};
            default: return {16'h0000, r[15:2], 1'b0, r[0]};
        endcase
    endfunction

    task automatic build_program();
        int          pos;
        logic [31:0] w;
        pos = 0;
        while (pos < 2048) begin
            w = random_inst();
            halves[pos] = w[15:0];
            if (w[1:0] == 2'b11 && pos < 2047) begin
                halves[pos + 1] = w[31:16];
                pos += 2;
            end else begin
                pos += 1;                 // last word wraps onto the first half-word
            end
        end
    endtask

    // expected beat at pc from the decode rules and the model stack
    function automatic fetch_pkg::fetch_out_t predict(input logic [fetch_pkg::XLEN-1:0] pc);
        fetch_pkg::fetch_out_t e;
        logic [31:0]           ir;
        logic [63:0]           seq;
        logic                  link_rd;
        logic                  link_rs1;
        e  = '0;
        ir = {half_at(pc + 64'd2), half_at(pc)};
        e.pc         = pc;
        e.compressed = ir[1:0] != 2'b11;
        if (e.compressed) ir[31:16] = 16'h0000;
        e.ir     = ir;
        seq      = pc + (e.compressed ? 64'd2 : 64'd4);
        e.target = seq;
        link_rd  = ir[11:7] == 5'd1 || ir[11:7] == 5'd5;
        link_rs1 = ir[19:15] == 5'd1 || ir[19:15] == 5'd5;
        if (!e.compressed) begin
            if (ir[6:0] == 7'h63) begin
                e.kind   = fetch_pkg::KIND_BRANCH;
                e.target = pc + {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            end else if (ir[6:0] == 7'h6f) begin
                e.kind   = fetch_pkg::KIND_JAL;
                e.call   = link_rd;
                e.target = pc + {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            end else if (ir[6:0] == 7'h67) begin
                e.kind = fetch_pkg::KIND_JALR;
                e.call = link_rd;
                e.ret  = link_rs1 && ir[19:15] != ir[11:7];
            end
        end else if (ir[15:13] == 3'b101 && ir[1:0] == 2'b01) begin  // c.j
            e.kind   = fetch_pkg::KIND_JAL;
            e.target = pc + {{52{ir[12]}}, ir[12], ir[8], ir[10:9], ir[6], ir[7], ir[2],
                             ir[11], ir[5:3], 1'b0};
        end else if (ir[15:14] == 2'b11 && ir[1:0] == 2'b01) begin
            e.kind   = fetch_pkg::KIND_BRANCH;
            e.target = pc + {{55{ir[12]}}, ir[12], ir[6:5], ir[2], ir[11:10], ir[4:3], 1'b0};
        end else if (ir[15:13] == 3'b100 && ir[1:0] == 2'b10 && ir[6:2] == 5'd0
                     && ir[11:7] != 5'd0) begin
            e.kind = fetch_pkg::KIND_JALR;   // c.jr, c.jalr
            e.call = ir[12];
            e.ret  = !ir[12] && link_rd;
        end
        if (e.ret && ras.size() > 0) e.target = ras[$];
        e.pred_npc = (e.kind == fetch_pkg::KIND_JAL || (e.ret && ras.size() > 0)) ? e.target : seq;
        return e;
    endfunction

    task automatic update_stack(input fetch_pkg::fetch_out_t e);
        if (e.ret && ras.size() > 0) void'(ras.pop_back());
        if (e.call) begin
            ras.push_back(e.pc + (e.compressed ? 64'd2 : 64'd4));
            if (ras.size() > fetch_pkg::RAS_DEPTH) void'(ras.pop_front());  // oldest lost
        end
    endtask

    task automatic check_out(input fetch_pkg::fetch_out_t got, input fetch_pkg::fetch_out_t exp);
        if (got !== exp) begin
            if (got.pc !== exp.pc)
                $display("mismatch out.pc: got %h expected %h", got.pc, exp.pc);
            if (got.ir !== exp.ir)
                $display("mismatch out.ir: got %h expected %h", got.ir, exp.ir);
            if (got.compressed !== exp.compressed)
                $display("mismatch out.compressed: got %h expected %h",
                         got.compressed, exp.compressed);
            if (got.kind !== exp.kind)
                $display("mismatch out.kind: got %h expected %h", got.kind, exp.kind);
            if (got.call !== exp.call)
                $display("mismatch out.call: got %h expected %h", got.call, exp.call);
            if (got.ret !== exp.ret)
                $display("mismatch out.ret: got %h expected %h", got.ret, exp.ret);
            if (got.target !== exp.target)
                $display("mismatch out.target: got %h expected %h", got.target, exp.target);
            if (got.pred_npc !== exp.pred_npc)
                $display("mismatch out.pred_npc: got %h expected %h",
                         got.pred_npc, exp.pred_npc);
            errors++;
            abort_run();
        end
    endtask

    task automatic check_req(input fetch_pkg::mem_req_t req);
        if (req.addr[3:0] !== 4'h0) begin
            $display("mismatch mem_req.addr: got %h expected %h", req.addr,
                     {req.addr[63:4], 4'h0});
            errors++;
            abort_run();
        end
    endtask

    task automatic stimulus_step();
        fetch_pkg::fetch_out_t exp;
        longint                due;
        cycle++;
        if (fetch_top_inst.fetch_props_inst.violations != 0) begin
            $display("a handshake assertion failed");
            errors++;
            abort_run();
        end
        if (mem_req_valid && mem_req_ready) begin
            check_req(mem_req);
            due = cycle + longint'($urandom_range(1, 6));
            if (due <= last_due) due = last_due + 1;  // keep responses in order
            last_due = due;
            rsp_addr.push_back(mem_req.addr);
            rsp_due.push_back(due);
        end
        if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
            mem_rsp_valid <= 1'b1;
            mem_rsp.data  <= line_data(rsp_addr.pop_front());
            void'(rsp_due.pop_front());
        end else begin
            mem_rsp_valid <= 1'b0;
        end
        mem_req_ready <= $urandom_range(0, 3) != 0;
        if (out_valid && out_ready) begin
            exp = predict(model_pc);
            check_out(out, exp);
            update_stack(exp);
            model_pc = exp.pred_npc;
            beats++;
        end
        out_ready <= $urandom_range(0, 9) < 7;  // about 70 % ready
        if (redirect_valid) begin
            model_pc = redirect.pc;               // backend restart empties the stack
            ras.delete();
            redirect_valid <= 1'b0;
        end else if (gap == 0) begin
            redirect_valid <= 1'b1;
            redirect.pc    <= {fetch_pkg::RESET_PC[63:12], 11'($urandom), 1'b0};
            gap = $urandom_range(40, 120);
        end else begin
            gap = gap - 1;
        end
    endtask

    initial begin
        void'($urandom(32'h3baf_dd28));
        rst            <= 1'b1;
        mem_req_ready  <= 1'b0;
        mem_rsp_valid  <= 1'b0;
        mem_rsp        <= '0;
        redirect_valid <= 1'b0;
        redirect       <= '0;
        out_ready      <= 1'b0;
        model_pc = fetch_pkg::RESET_PC;
        cycle    = 0;
        last_due = 0;
        beats    = 0;
        errors   = 0;
        gap      = $urandom_range(40, 120);
        build_program();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (beats < BEATS) begin
            @(posedge clk);
            stimulus_step();
        end
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the fetch front end stopped delivering beats");
        abort_run();
    end

endmodule
